//--- fdc_core.f
hw/fdc_pkg.sv
hw/fdc_host_regs.sv
hw/fdc_seek_unit.sv
hw/fdc_sector_reader.sv
hw/fdc_core.sv
test/fdc_core_tb.sv

//--- test/fdc_core_tb.sv
`timescale 1ns/1ps
// FDC core testbench with a drive model, reference payload and directed command tests
module fdc_core_tb;

	// Filler bytes around each ID and data field
	localparam int GAP_BYTES = 4;
	// Index slot plus four sectors at three clocks per byte
	localparam int REV_CYCLES = 2 + 4 * 3 * (132 + 2 * GAP_BYTES);
	// Record not found takes up to six revolutions, each read up to two, seeks well under one
	localparam int TIMEOUT_CYCLES = 12 * REV_CYCLES;
	localparam logic [31:0] SEED = 32'h1092_96e9;

	logic               clk = 1'b0;
	logic               rst;
	logic               cs;
	logic               rd;
	logic               wr;
	fdc_pkg::fdc_addr_t addr;
	fdc_pkg::fdc_byte_t din;
	fdc_pkg::fdc_byte_t dout;
	logic               intrq;
	logic               drq;
	logic               step;
	logic               dir;
	logic               trk00;
	logic               index_pulse;
	logic               disk_valid;
	fdc_pkg::fdc_byte_t disk_byte;
	logic               disk_idam;
	logic               disk_dam;

	// Drive model state
	int                 head = 7;
	int                 up_steps;
	int                 down_steps;
	int                 idx_seen;
	// Bookkeeping
	int                 cycles;
	int                 checks;
	int                 errors;
	int                 tests_run;
	int                 tests_failed;
	int                 err_mark;
	fdc_pkg::fdc_byte_t rd_val;

	fdc_core dut (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	// Expected payload mixing track, sector and byte index into the seed
	function automatic fdc_pkg::fdc_byte_t ref_sector_byte(input fdc_pkg::fdc_byte_t trk,
		input fdc_pkg::fdc_byte_t sec, input int n);
		logic [31:0] x;
		x = lcg_next(SEED ^ {trk, sec, n[15:0]});
		x = lcg_next(x);
		return x[23:16];
	endfunction

	// Expected status byte from its flags
	function automatic fdc_pkg::fdc_byte_t status_byte(input logic busy, input logic req,
		input logic flag2, input logic err);
		fdc_pkg::fdc_byte_t s;
		s = '0;
		s[fdc_pkg::ST_BUSY] = busy;
		s[fdc_pkg::ST_DRQ] = req;
		s[fdc_pkg::ST_LOST_TRK00] = flag2;
		s[fdc_pkg::ST_ERROR] = err;
		return s;
	endfunction

	task automatic check_byte(input string name, input fdc_pkg::fdc_byte_t exp,
		input fdc_pkg::fdc_byte_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	// Host write strobes held for one cycle so the write lands on the second edge
	task automatic bus_write(input fdc_pkg::fdc_addr_t a, input fdc_pkg::fdc_byte_t v);
		@(posedge clk);
		cs <= 1'b1;
		wr <= 1'b1;
		addr <= a;
		din <= v;
		@(posedge clk);
		cs <= 1'b0;
		wr <= 1'b0;
	endtask

	// dout sampled mid cycle while rd is held
	task automatic bus_read(input fdc_pkg::fdc_addr_t a, output fdc_pkg::fdc_byte_t v);
		@(posedge clk);
		cs <= 1'b1;
		rd <= 1'b1;
		addr <= a;
		@(negedge clk);
		v = dout;
		@(posedge clk);
		cs <= 1'b0;
		rd <= 1'b0;
	endtask

	task automatic wait_intrq();
		do @(negedge clk); while (!intrq);
	endtask

	// Reads the next payload byte once DRQ is up
	task automatic read_data_byte(input fdc_pkg::fdc_byte_t sec, input int n);
		do @(negedge clk); while (!drq);
		bus_read(fdc_pkg::A_DATA, rd_val);
		check_byte("data", ref_sector_byte(8'd12, sec, n), rd_val);
	endtask

	// Cleared between edges so the monitors never race
	task automatic clear_counters();
		@(negedge clk);
		up_steps = 0;
		down_steps = 0;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	// Head moves one track per pulse and never below 0
	always @(posedge clk) begin
		if (step) begin
			if (dir) begin
				up_steps++;
				head <= head + 1;
				trk00 <= 1'b0;
			end else begin
				down_steps++;
				if (head > 0) begin
					head <= head - 1;
					trk00 <= head == 1;
				end
			end
		end
		if (index_pulse) begin
			idx_seen++;
		end
	end

	// One decoded byte every three clocks
	task automatic send_byte(input fdc_pkg::fdc_byte_t b, input logic idam, input logic dam);
		@(posedge clk);
		disk_valid <= 1'b1;
		disk_byte <= b;
		disk_idam <= idam;
		disk_dam <= dam;
		@(posedge clk);
		disk_valid <= 1'b0;
		disk_idam <= 1'b0;
		disk_dam <= 1'b0;
		@(posedge clk);
	endtask

	// Index pulse followed by sectors 1 to 4 with ID, gap, data and gap
	task automatic play_revolution();
		fdc_pkg::fdc_byte_t trk;
		@(posedge clk);
		index_pulse <= 1'b1;
		@(posedge clk);
		index_pulse <= 1'b0;
		for (int s = 1; s <= 4; s++) begin
			trk = fdc_pkg::fdc_byte_t'(head);
			send_byte(trk, 1'b1, 1'b0);
			send_byte(8'h00, 1'b0, 1'b0);
			send_byte(fdc_pkg::fdc_byte_t'(s), 1'b0, 1'b0);
			// Size code 0 means 128 bytes
			send_byte(8'h00, 1'b0, 1'b0);
			repeat (GAP_BYTES) send_byte(8'h4e, 1'b0, 1'b0);
			for (int n = 0; n < 128; n++) begin
				send_byte(ref_sector_byte(trk, fdc_pkg::fdc_byte_t'(s), n), 1'b0, n == 0);
			end
			repeat (GAP_BYTES) send_byte(8'h4e, 1'b0, 1'b0);
		end
	endtask

	initial begin
		forever play_revolution();
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, a command never completed", cycles);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		rst <= 1'b1;
		cs <= 1'b0;
		rd <= 1'b0;
		wr <= 1'b0;
		addr <= '0;
		din <= '0;
		trk00 <= 1'b0;
		index_pulse <= 1'b0;
		disk_valid <= 1'b0;
		disk_byte <= '0;
		disk_idam <= 1'b0;
		disk_dam <= 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		err_mark = 0;

		// Restore from track 7
		clear_counters();
		bus_write(fdc_pkg::A_COMMAND, 8'h00);
		wait_intrq();
		check_byte("down steps", 8'd7, fdc_pkg::fdc_byte_t'(down_steps));
		check_byte("up steps", 8'd0, fdc_pkg::fdc_byte_t'(up_steps));
		bus_read(fdc_pkg::A_TRACK, rd_val);
		check_byte("track", 8'd0, rd_val);
		// A track read leaves the interrupt pending
		@(negedge clk);
		check_bit("intrq", 1'b1, intrq);
		bus_read(fdc_pkg::A_STATUS, rd_val);
		check_byte("status", status_byte(1'b0, 1'b0, 1'b1, 1'b0), rd_val);
		@(negedge clk);
		check_bit("intrq", 1'b0, intrq);
		end_test("restore");

		// Seek outward to track 12
		bus_write(fdc_pkg::A_DATA, 8'd12);
		clear_counters();
		bus_write(fdc_pkg::A_COMMAND, 8'h10);
		wait_intrq();
		check_byte("up steps", 8'd12, fdc_pkg::fdc_byte_t'(up_steps));
		check_byte("down steps", 8'd0, fdc_pkg::fdc_byte_t'(down_steps));
		check_byte("head", 8'd12, fdc_pkg::fdc_byte_t'(head));
		bus_read(fdc_pkg::A_STATUS, rd_val);
		check_byte("status", status_byte(1'b0, 1'b0, 1'b0, 1'b0), rd_val);
		bus_read(fdc_pkg::A_TRACK, rd_val);
		check_byte("track", 8'd12, rd_val);
		end_test("seek");

		// Full sector read
		bus_write(fdc_pkg::A_SECTOR, 8'd3);
		bus_write(fdc_pkg::A_COMMAND, 8'h80);
		for (int n = 0; n < 128; n++) begin
			read_data_byte(8'd3, n);
		end
		wait_intrq();
		check_bit("drq", 1'b0, drq);
		bus_read(fdc_pkg::A_STATUS, rd_val);
		check_byte("status", status_byte(1'b0, 1'b0, 1'b0, 1'b0), rd_val);
		end_test("read sector 3");

		// Sector absent from the image
		bus_write(fdc_pkg::A_SECTOR, 8'd9);
		bus_write(fdc_pkg::A_COMMAND, 8'h80);
		@(posedge clk);
		@(negedge clk);
		idx_seen = 0;
		wait_intrq();
		check_byte("index pulses", fdc_pkg::fdc_byte_t'(fdc_pkg::INDEX_LIMIT),
			fdc_pkg::fdc_byte_t'(idx_seen));
		bus_read(fdc_pkg::A_STATUS, rd_val);
		check_byte("status", status_byte(1'b0, 1'b0, 1'b0, 1'b1), rd_val);
		end_test("record not found");

		// Host stops reading after 10 bytes
		bus_write(fdc_pkg::A_SECTOR, 8'd2);
		bus_write(fdc_pkg::A_COMMAND, 8'h80);
		for (int n = 0; n < 10; n++) begin
			read_data_byte(8'd2, n);
		end
		wait_intrq();
		check_bit("drq", 1'b1, drq);
		bus_read(fdc_pkg::A_STATUS, rd_val);
		check_byte("status", status_byte(1'b0, 1'b1, 1'b1, 1'b0), rd_val);
		end_test("lost data");

		// Track write during a busy seek is dropped
		bus_write(fdc_pkg::A_DATA, 8'd5);
		clear_counters();
		bus_write(fdc_pkg::A_COMMAND, 8'h10);
		bus_write(fdc_pkg::A_TRACK, 8'd99);
		bus_read(fdc_pkg::A_STATUS, rd_val);
		check_bit("busy", 1'b1, rd_val[fdc_pkg::ST_BUSY]);
		wait_intrq();
		check_byte("down steps", 8'd7, fdc_pkg::fdc_byte_t'(down_steps));
		check_byte("head", 8'd5, fdc_pkg::fdc_byte_t'(head));
		bus_read(fdc_pkg::A_TRACK, rd_val);
		check_byte("track", 8'd5, rd_val);
		end_test("busy lockout");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- hw/fdc_core.sv
`timescale 1ns/1ps
// FDC core top that joins the host register file, the positioner and the sector reader
module fdc_core (
	input  logic               clk,
	input  logic               rst,
	input  logic               cs,
	input  logic               rd,
	input  logic               wr,
	input  fdc_pkg::fdc_addr_t addr,
	input  fdc_pkg::fdc_byte_t din,
	output fdc_pkg::fdc_byte_t dout,
	output logic               intrq,
	output logic               drq,
	output logic               step,
	output logic               dir,
	input  logic               trk00,
	input  logic               index_pulse,
	input  logic               disk_valid,
	input  fdc_pkg::fdc_byte_t disk_byte,
	input  logic               disk_idam,
	input  logic               disk_dam
);
	// Command issue
	fdc_pkg::fdc_byte_t cmd;
	logic               cmd_start;
	// Register contents seen by the engines
	fdc_pkg::fdc_byte_t track;
	fdc_pkg::fdc_byte_t sector;
	fdc_pkg::fdc_byte_t data;
	// Positioner results
	logic               seek_busy;
	fdc_pkg::fdc_byte_t seek_status;
	logic               seek_done;
	fdc_pkg::fdc_byte_t track_out;
	logic               track_write;
	// Reader results
	logic               read_busy;
	logic               read_error;
	logic               read_done;
	fdc_pkg::fdc_byte_t data_byte;
	logic               data_valid;

	fdc_host_regs regs (.*);

	// Data register doubles as the seek target
	fdc_seek_unit seek (.target(data), .*);

	fdc_sector_reader reader (.*);

endmodule

//--- hw/fdc_sector_reader.sv
`timescale 1ns/1ps
// Type II sector reader that matches an ID field in the disk stream and forwards the data bytes
module fdc_sector_reader (
	input  logic               clk,
	input  logic               rst,
	input  fdc_pkg::fdc_byte_t cmd,
	input  logic               cmd_start,
	input  fdc_pkg::fdc_byte_t track,
	input  fdc_pkg::fdc_byte_t sector,
	input  logic               index_pulse,
	input  logic               disk_valid,
	input  fdc_pkg::fdc_byte_t disk_byte,
	input  logic               disk_idam,
	input  logic               disk_dam,
	output fdc_pkg::fdc_byte_t data_byte,
	output logic               data_valid,
	output logic               read_busy,
	output logic               read_error,
	output logic               read_done
);
	fdc_pkg::read_state_t state;
	logic                 accept;
	logic                 take;
	logic                 hunting;
	logic [1:0]           id_cnt;
	fdc_pkg::fdc_byte_t   id_track;
	fdc_pkg::fdc_byte_t   id_sector;
	fdc_pkg::index_cnt_t  idx_cnt;
	fdc_pkg::sec_len_t    remaining;

	assign accept = cmd_start && cmd[7:4] == fdc_pkg::CMD_READ;

	// Bytes passed on to the data register
	assign take = disk_valid && ((state == fdc_pkg::RD_WAIT_DAM && disk_dam) ||
		(state == fdc_pkg::RD_DATA && remaining != '0));

	// Revolutions count until the data field starts
	assign hunting = state inside {fdc_pkg::RD_HUNT, fdc_pkg::RD_ID} ||
		(state == fdc_pkg::RD_WAIT_DAM && !take);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fdc_pkg::RD_IDLE;
			read_error <= 1'b0;
			id_cnt <= '0;
			idx_cnt <= '0;
			remaining <= '0;
		end else begin
			case (state)
				fdc_pkg::RD_IDLE: begin
					if (accept) begin
						read_error <= 1'b0;
						idx_cnt <= '0;
						state <= fdc_pkg::RD_HUNT;
					end
				end
				fdc_pkg::RD_HUNT: begin
					// Address mark byte is the ID track
					if (disk_valid && disk_idam) begin
						id_cnt <= 2'd1;
						state <= fdc_pkg::RD_ID;
					end
				end
				fdc_pkg::RD_ID: begin
					if (disk_valid) begin
						id_cnt <= id_cnt + 2'd1;
						// Size code is the last ID byte
						if (id_cnt == 2'd3) begin
							if (id_track == track && id_sector == sector) begin
								remaining <= fdc_pkg::sec_len_t'(128) << disk_byte[1:0];
								state <= fdc_pkg::RD_WAIT_DAM;
							end else begin
								state <= fdc_pkg::RD_HUNT;
							end
						end
					end
				end
				fdc_pkg::RD_WAIT_DAM: begin
					if (take) begin
						remaining <= remaining - 1'b1;
						state <= fdc_pkg::RD_DATA;
					end
				end
				fdc_pkg::RD_DATA: begin
					// Stay one cycle past the last byte so it leaves from here
					if (remaining == '0) begin
						state <= fdc_pkg::RD_FINISH;
					end else if (take) begin
						remaining <= remaining - 1'b1;
					end
				end
				fdc_pkg::RD_FINISH: state <= fdc_pkg::RD_IDLE;
				default: state <= fdc_pkg::RD_IDLE;
			endcase
			// Record not found
			if (hunting && index_pulse) begin
				if (idx_cnt == fdc_pkg::index_cnt_t'(fdc_pkg::INDEX_LIMIT - 1)) begin
					read_error <= 1'b1;
					state <= fdc_pkg::RD_FINISH;
				end else begin
					idx_cnt <= idx_cnt + 1'b1;
				end
			end
		end
	end

	// ID fields kept for the compare
	always_ff @(posedge clk) begin
		if (state == fdc_pkg::RD_HUNT && disk_valid && disk_idam) begin
			id_track <= disk_byte;
		end
		if (state == fdc_pkg::RD_ID && disk_valid && id_cnt == 2'd2) begin
			id_sector <= disk_byte;
		end
	end

	// One cycle from disk to host side
	always_ff @(posedge clk) begin
		if (rst) begin
			data_valid <= 1'b0;
		end else begin
			data_valid <= take;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			data_byte <= disk_byte;
		end
	end

	assign read_busy = state != fdc_pkg::RD_IDLE;
	assign read_done = state == fdc_pkg::RD_FINISH;

	// Payload never leaks outside the data field
	assert property (@(posedge clk) disable iff (rst) data_valid |-> state == fdc_pkg::RD_DATA);

endmodule

//--- hw/fdc_seek_unit.sv
`timescale 1ns/1ps
// Type I positioner that steps the head for restore and seek and updates the track register
module fdc_seek_unit (
	input  logic               clk,
	input  logic               rst,
	input  fdc_pkg::fdc_byte_t cmd,
	input  logic               cmd_start,
	input  fdc_pkg::fdc_byte_t track,
	input  fdc_pkg::fdc_byte_t target,
	input  logic               trk00,
	output logic               step,
	output logic               dir,
	output fdc_pkg::fdc_byte_t track_out,
	output logic               track_write,
	output logic               seek_busy,
	output fdc_pkg::fdc_byte_t seek_status,
	output logic               seek_done
);
	fdc_pkg::seek_state_t state;
	logic                 accept;
	logic                 restore;
	logic                 seek_err;
	fdc_pkg::fdc_byte_t   dest;
	fdc_pkg::fdc_byte_t   step_cnt;
	fdc_pkg::step_cnt_t   wait_cnt;

	// Only restore and seek start this engine
	assign accept = cmd_start &&
		(cmd[7:4] == fdc_pkg::CMD_RESTORE || cmd[7:4] == fdc_pkg::CMD_SEEK);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fdc_pkg::SEEK_IDLE;
			restore <= 1'b0;
			seek_err <= 1'b0;
			dir <= 1'b0;
			step_cnt <= '0;
			wait_cnt <= '0;
		end else begin
			case (state)
				fdc_pkg::SEEK_IDLE: begin
					if (accept) begin
						restore <= cmd[7:4] == fdc_pkg::CMD_RESTORE;
						seek_err <= 1'b0;
						step_cnt <= '0;
						state <= fdc_pkg::SEEK_DECIDE;
					end
				end
				fdc_pkg::SEEK_DECIDE: begin
					if (restore) begin
						// Step outward until track 0 or the limit
						if (trk00) begin
							state <= fdc_pkg::SEEK_FINISH;
						end else if (step_cnt == fdc_pkg::fdc_byte_t'(fdc_pkg::RESTORE_LIMIT)) begin
							seek_err <= 1'b1;
							state <= fdc_pkg::SEEK_FINISH;
						end else begin
							dir <= 1'b0;
							state <= fdc_pkg::SEEK_PULSE;
						end
					end else if (track == dest) begin
						state <= fdc_pkg::SEEK_FINISH;
					end else begin
						// Toward the centre when the target is higher
						dir <= dest > track;
						state <= fdc_pkg::SEEK_PULSE;
					end
				end
				fdc_pkg::SEEK_PULSE: begin
					step_cnt <= step_cnt + 8'd1;
					wait_cnt <= '0;
					state <= fdc_pkg::SEEK_SETTLE;
				end
				fdc_pkg::SEEK_SETTLE: begin
					// Pulse and decide cycles complete the step period
					if (wait_cnt == fdc_pkg::step_cnt_t'(fdc_pkg::STEP_CYCLES - 3)) begin
						state <= fdc_pkg::SEEK_DECIDE;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				fdc_pkg::SEEK_FINISH: state <= fdc_pkg::SEEK_IDLE;
				default: state <= fdc_pkg::SEEK_IDLE;
			endcase
		end
	end

	// Target held for the whole seek
	always_ff @(posedge clk) begin
		if (state == fdc_pkg::SEEK_IDLE && accept) begin
			dest <= target;
		end
	end

	assign step      = state == fdc_pkg::SEEK_PULSE;
	assign seek_busy = state != fdc_pkg::SEEK_IDLE;
	assign seek_done = state == fdc_pkg::SEEK_FINISH;

	// Seek tracks each pulse and restore writes 0 once track 00 is found
	assign track_write = (step && !restore) || (seek_done && restore && !seek_err);
	assign track_out   = restore ? '0 : (dir ? track + 8'd1 : track - 8'd1);

	always_comb begin
		seek_status = '0;
		seek_status[fdc_pkg::ST_BUSY] = seek_busy;
		seek_status[fdc_pkg::ST_LOST_TRK00] = trk00;
		seek_status[fdc_pkg::ST_ERROR] = seek_err;
	end

	// Step pulses stay inside a command and are a full step period apart
	assert property (@(posedge clk) disable iff (rst)
		step |-> seek_busy ##1 !step [*(fdc_pkg::STEP_CYCLES - 1)]);

endmodule

//--- hw/fdc_host_regs.sv
`timescale 1ns/1ps
// FDC host register file with busy lockout, data handshake, lost data and status combining
module fdc_host_regs (
	input  logic               clk,
	input  logic               rst,
	input  logic               cs,
	input  logic               rd,
	input  logic               wr,
	input  fdc_pkg::fdc_addr_t addr,
	input  fdc_pkg::fdc_byte_t din,
	output fdc_pkg::fdc_byte_t dout,
	output logic               intrq,
	output logic               drq,
	output fdc_pkg::fdc_byte_t cmd,
	output logic               cmd_start,
	output fdc_pkg::fdc_byte_t track,
	output fdc_pkg::fdc_byte_t sector,
	output fdc_pkg::fdc_byte_t data,
	input  logic               seek_busy,
	input  fdc_pkg::fdc_byte_t seek_status,
	input  logic               seek_done,
	input  fdc_pkg::fdc_byte_t track_out,
	input  logic               track_write,
	input  logic               read_busy,
	input  logic               read_error,
	input  logic               read_done,
	input  fdc_pkg::fdc_byte_t data_byte,
	input  logic               data_valid
);
	logic               busy;
	logic               wr_cmd;
	logic               wr_track;
	logic               wr_sector;
	logic               wr_data;
	logic               rd_status;
	logic               rd_data;
	logic               last_read;
	logic               lost_data;
	fdc_pkg::fdc_byte_t status;

	// Busy covers the start cycle before either engine reacts
	assign busy = cmd_start | seek_busy | read_busy;

	// Write strobes, one cycle each
	assign wr_cmd    = cs && wr && addr == fdc_pkg::A_COMMAND;
	assign wr_track  = cs && wr && addr == fdc_pkg::A_TRACK;
	assign wr_sector = cs && wr && addr == fdc_pkg::A_SECTOR;
	assign wr_data   = cs && wr && addr == fdc_pkg::A_DATA;
	// Read side effects land on the edge closing the read cycle
	assign rd_status = cs && rd && addr == fdc_pkg::A_STATUS;
	assign rd_data   = cs && rd && addr == fdc_pkg::A_DATA;

	// Status byte follows whichever engine ran last
	always_comb begin
		if (last_read) begin
			status = '0;
			status[fdc_pkg::ST_DRQ] = drq;
			status[fdc_pkg::ST_LOST_TRK00] = lost_data;
			status[fdc_pkg::ST_ERROR] = read_error;
		end else begin
			status = seek_status;
		end
		status[fdc_pkg::ST_BUSY] = busy;
	end

	// Read mux, bus idles high
	always_comb begin
		dout = '1;
		if (cs && rd) begin
			case (addr)
				fdc_pkg::A_STATUS: dout = status;
				fdc_pkg::A_TRACK:  dout = track;
				fdc_pkg::A_SECTOR: dout = sector;
				default:           dout = data;
			endcase
		end
	end

	// Command accepted only when idle
	always_ff @(posedge clk) begin
		if (rst) begin
			cmd_start <= 1'b0;
		end else begin
			cmd_start <= wr_cmd && !busy;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_cmd && !busy) begin
			cmd <= din;
		end
	end

	// Which engine owns the status byte
	always_ff @(posedge clk) begin
		if (rst) begin
			last_read <= 1'b0;
		end else if (read_busy) begin
			last_read <= 1'b1;
		end else if (seek_busy) begin
			last_read <= 1'b0;
		end
	end

	// Track register, positioner updates win over the host
	always_ff @(posedge clk) begin
		if (rst) begin
			track <= '0;
		end else if (track_write) begin
			track <= track_out;
		end else if (wr_track && !busy) begin
			track <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sector <= 8'd1;
		end else if (wr_sector && !busy) begin
			sector <= din;
		end
	end

	// Data register, also the seek target
	always_ff @(posedge clk) begin
		if (data_valid) begin
			data <= data_byte;
		end else if (wr_data) begin
			data <= din;
		end
	end

	// DRQ and sticky lost data
	always_ff @(posedge clk) begin
		if (rst) begin
			drq <= 1'b0;
			lost_data <= 1'b0;
		end else if (cmd_start) begin
			drq <= 1'b0;
			lost_data <= 1'b0;
		end else if (data_valid) begin
			drq <= 1'b1;
			// Old byte overwritten unread
			if (drq && !rd_data) begin
				lost_data <= 1'b1;
			end
		end else if (rd_data) begin
			drq <= 1'b0;
		end
	end

	// Interrupt on completion, acknowledged by a status read or a new command
	always_ff @(posedge clk) begin
		if (rst) begin
			intrq <= 1'b0;
		end else if (seek_done || read_done) begin
			intrq <= 1'b1;
		end else if (rd_status || cmd_start) begin
			intrq <= 1'b0;
		end
	end

	// Lockout keeps engines from being restarted mid command
	assert property (@(posedge clk) disable iff (rst) cmd_start |-> !(seek_busy || read_busy));
	// Only one engine may run at a time
	assert property (@(posedge clk) disable iff (rst) !(seek_busy && read_busy));

endmodule

//--- hw/fdc_pkg.sv
// FDC core shared types, register map, status bits, command codes, timing limits and FSM states
package fdc_pkg;

	// Host bus, register and disk stream byte
	typedef logic [7:0] fdc_byte_t;
	// Host register select
	typedef logic [1:0] fdc_addr_t;

	// Register map
	// Command on write and status on read share address 0
	localparam fdc_addr_t A_COMMAND = 2'd0;
	localparam fdc_addr_t A_STATUS  = 2'd0;
	localparam fdc_addr_t A_TRACK   = 2'd1;
	localparam fdc_addr_t A_SECTOR  = 2'd2;
	localparam fdc_addr_t A_DATA    = 2'd3;

	// Status bit positions
	localparam int ST_BUSY       = 0;
	localparam int ST_DRQ        = 1;
	// Track 00 for type I, lost data for type II
	localparam int ST_LOST_TRK00 = 2;
	// Seek error for type I, record not found for type II
	localparam int ST_ERROR      = 4;

	// Upper nibble of the command byte
	localparam logic [3:0] CMD_RESTORE = 4'h0;
	localparam logic [3:0] CMD_SEEK    = 4'h1;
	localparam logic [3:0] CMD_READ    = 4'h8;

	// Cycles from one step pulse to the next
	localparam int STEP_CYCLES   = 16;
	// Steps allowed before restore gives up
	localparam int RESTORE_LIMIT = 255;
	// Revolutions without a matching ID
	localparam int INDEX_LIMIT   = 5;

	// Counters sized from the limits above
	typedef logic [$clog2(STEP_CYCLES)-1:0]   step_cnt_t;
	typedef logic [$clog2(INDEX_LIMIT+1)-1:0] index_cnt_t;
	// Sector payload length, 128 up to 1024 bytes
	typedef logic [10:0] sec_len_t;

	// Positioner FSM
	typedef enum logic [2:0] {
		SEEK_IDLE, SEEK_DECIDE, SEEK_PULSE, SEEK_SETTLE, SEEK_FINISH
	} seek_state_t;

	// Sector reader FSM
	typedef enum logic [2:0] {
		RD_IDLE, RD_HUNT, RD_ID, RD_WAIT_DAM, RD_DATA, RD_FINISH
	} read_state_t;

endpackage
